// File: cordic_pkg.sv
`default_nettype none

package cordic_pkg;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  // whole degrees, -180..180
  typedef logic signed [15:0] angle_deg_t;
  typedef logic signed [11:0] amp_t;
  typedef logic signed [15:0] sample_t;
  // output width plus 16 fraction bits
  typedef logic signed [31:0] cordic_acc_t;
  typedef logic        [2:0]  wb_adr_t;
  typedef logic        [31:0] wb_dat_t;

  ////////////////////////////////////////////////////////////
  // cordic constants
  ////////////////////////////////////////////////////////////

  localparam int ITER_NUM     = 16;
  localparam int FRAC_BITS    = 16;
  localparam int PIPE_LATENCY = 20;

  // 0.607253 * 2^16
  localparam cordic_acc_t GAIN_COMP = 32'sd39797;

  // atan(2^-i) in degrees, scaled by 2^16
  localparam cordic_acc_t ATAN_TABLE [ITER_NUM] = '{
    32'sd2949120, 32'sd1740967, 32'sd919879, 32'sd466945,
    32'sd234379,  32'sd117304,  32'sd58666,  32'sd29335,
    32'sd14668,   32'sd7334,    32'sd3667,   32'sd1833,
    32'sd917,     32'sd458,     32'sd229,    32'sd115
  };

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  localparam wb_adr_t REG_CTRL   = 3'd0;
  localparam wb_adr_t REG_AMP    = 3'd1;
  localparam wb_adr_t REG_START  = 3'd2;
  localparam wb_adr_t REG_STEP   = 3'd3;
  localparam wb_adr_t REG_RESULT = 3'd4;
  localparam wb_adr_t REG_COUNT  = 3'd5;

  localparam int CTRL_RUN_BIT  = 0;
  localparam int CTRL_SHOT_BIT = 1;

  // largest sweep step in degrees
  localparam angle_deg_t STEP_MAX = 16'sd90;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_req_t;

  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_rsp_t;

  typedef struct packed {
    logic       valid;
    angle_deg_t angle;
    amp_t       amp;
  } angle_sample_t;

  // first quadrant angle and magnitude plus output signs
  typedef struct packed {
    logic        valid;
    logic [6:0]  angle;
    logic [10:0] mag;
    logic        neg_x;
    logic        neg_y;
  } fold_t;

  typedef struct packed {
    logic    valid;
    sample_t cos;
    sample_t sin;
  } phasor_t;

endpackage

`default_nettype wire

// File: angle_fold.sv
`timescale 1ns/1ns
`default_nettype none

module angle_fold (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire cordic_pkg::angle_sample_t sample,
  output cordic_pkg::fold_t         folded
);

  import cordic_pkg::*;

  angle_deg_t  abs_angle;
  logic        ang_neg;
  logic        amp_neg;
  logic        over_90;
  logic [6:0]  fold_angle;
  logic [10:0] mag;

  logic        vld_q;
  logic [6:0]  angle_q;
  logic [10:0] mag_q;
  logic        neg_x_q;
  logic        neg_y_q;

  always_comb begin
    ang_neg   = sample.angle < 0;
    abs_angle = ang_neg ? -sample.angle : sample.angle;
    // second quadrant mirrors onto the first, cos flips sign
    over_90    = abs_angle > 16'sd90;
    fold_angle = over_90 ? 7'(180 - abs_angle) : 7'(abs_angle);

    amp_neg = sample.amp[11];
    if (amp_neg && sample.amp[10:0] == 11'd0) begin
      // -2048 has no 11-bit magnitude
      mag = 11'd2047;
    end else if (amp_neg) begin
      mag = 11'(-sample.amp);
    end else begin
      mag = sample.amp[10:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= sample.valid;
    end
  end

  always_ff @(posedge clk) begin
    angle_q <= fold_angle;
    mag_q   <= mag;
    // negative amplitude flips both components
    neg_x_q <= over_90 ^ amp_neg;
    neg_y_q <= ang_neg ^ amp_neg;
  end

  assign folded = '{valid: vld_q, angle: angle_q, mag: mag_q,
                    neg_x: neg_x_q, neg_y: neg_y_q};

endmodule

`default_nettype wire

// File: cordic_rotator.sv
`timescale 1ns/1ns
`default_nettype none

module cordic_rotator (
  input  wire               clk,
  input  wire               arst_n,
  input  wire cordic_pkg::fold_t folded,
  output cordic_pkg::phasor_t    phasor
);

  import cordic_pkg::*;

  // x and y run from the load stage at index 0 to the last iteration at ITER_NUM
  cordic_acc_t x_q   [ITER_NUM+1];
  cordic_acc_t y_q   [ITER_NUM+1];
  // residual angle and target end at the input of the last iteration
  cordic_acc_t z_q   [ITER_NUM];
  cordic_acc_t tgt_q [ITER_NUM];

  logic [ITER_NUM:0] vld_q;
  logic [ITER_NUM:0] neg_x_q;
  logic [ITER_NUM:0] neg_y_q;

  cordic_acc_t gain_mag;
  cordic_acc_t x_int;
  cordic_acc_t y_int;
  sample_t     x_mag;
  sample_t     y_mag;

  logic        out_vld_q;
  sample_t     cos_q;
  sample_t     sin_q;

  ////////////////////////////////////////////////////////////
  // load stage
  ////////////////////////////////////////////////////////////

  // magnitude times gain as a sum of shifted copies
  always_comb begin
    gain_mag = '0;
    for (int b = 0; b < FRAC_BITS; b++) begin
      if (GAIN_COMP[b]) begin
        gain_mag = gain_mag + (cordic_acc_t'(folded.mag) <<< b);
      end
    end
  end

  always_ff @(posedge clk) begin
    x_q[0]   <= gain_mag;
    y_q[0]   <= '0;
    z_q[0]   <= '0;
    tgt_q[0] <= cordic_acc_t'(folded.angle) <<< FRAC_BITS;
  end

  ////////////////////////////////////////////////////////////
  // iterations
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < ITER_NUM; i++) begin : g_iter
    cordic_acc_t diff;

    assign diff = tgt_q[i] - z_q[i];

    always_ff @(posedge clk) begin
      if (!diff[31]) begin
        // rotate counterclockwise while short of the target
        x_q[i+1] <= x_q[i] - (y_q[i] >>> i);
        y_q[i+1] <= y_q[i] + (x_q[i] >>> i);
      end else begin
        x_q[i+1] <= x_q[i] + (y_q[i] >>> i);
        y_q[i+1] <= y_q[i] - (x_q[i] >>> i);
      end
    end

    // the last iteration leaves no residual angle to track
    if (i < ITER_NUM - 1) begin : g_angle
      always_ff @(posedge clk) begin
        if (!diff[31]) begin
          z_q[i+1] <= z_q[i] + ATAN_TABLE[i];
        end else begin
          z_q[i+1] <= z_q[i] - ATAN_TABLE[i];
        end
        tgt_q[i+1] <= tgt_q[i];
      end
    end
  end

  // signs travel alongside the data
  always_ff @(posedge clk) begin
    neg_x_q <= {neg_x_q[ITER_NUM-1:0], folded.neg_x};
    neg_y_q <= {neg_y_q[ITER_NUM-1:0], folded.neg_y};
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q     <= '0;
      out_vld_q <= 1'b0;
    end else begin
      vld_q     <= {vld_q[ITER_NUM-1:0], folded.valid};
      out_vld_q <= vld_q[ITER_NUM];
    end
  end

  ////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////

  assign x_int = x_q[ITER_NUM] >>> FRAC_BITS;
  assign y_int = y_q[ITER_NUM] >>> FRAC_BITS;

  // floor residue below zero clips to zero in the first quadrant
  always_comb begin
    x_mag = x_int[31] ? '0 : sample_t'(x_int);
    y_mag = y_int[31] ? '0 : sample_t'(y_int);
  end

  always_ff @(posedge clk) begin
    cos_q <= neg_x_q[ITER_NUM] ? -x_mag : x_mag;
    sin_q <= neg_y_q[ITER_NUM] ? -y_mag : y_mag;
  end

  assign phasor = '{valid: out_vld_q, cos: cos_q, sin: sin_q};

endmodule

`default_nettype wire

// File: phase_sweep.sv
`timescale 1ns/1ns
`default_nettype none

module phase_sweep (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire                        run,
  input  wire                        shot,
  input  wire cordic_pkg::amp_t      amp,
  input  wire cordic_pkg::angle_deg_t start,
  input  wire cordic_pkg::angle_deg_t step,
  output cordic_pkg::angle_sample_t  sample
);

  import cordic_pkg::*;

  logic       run_q;
  logic       vld_q;
  logic       restart;
  angle_deg_t angle_q;
  angle_deg_t sum;
  angle_deg_t next_angle;
  amp_t       amp_q;

  always_comb begin
    // a shot or a fresh run begins again at the start angle
    restart = shot | (run & ~run_q);
    sum     = angle_q + step;
    if (restart) begin
      next_angle = start;
    end else if (sum >= 16'sd180) begin
      next_angle = sum - 16'sd360;
    end else begin
      next_angle = sum;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_q   <= 1'b0;
      vld_q   <= 1'b0;
      angle_q <= '0;
    end else begin
      run_q <= run;
      vld_q <= shot | run;
      if (shot | run) begin
        angle_q <= next_angle;
      end
    end
  end

  // amplitude sampled alongside each angle
  always_ff @(posedge clk) begin
    amp_q <= amp;
  end

  assign sample = '{valid: vld_q, angle: angle_q, amp: amp_q};

endmodule

`default_nettype wire

// File: wb_cordic_regs.sv
`timescale 1ns/1ns
`default_nettype none

module wb_cordic_regs (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire cordic_pkg::wb_req_t wb_req,
  output cordic_pkg::wb_rsp_t    wb_rsp,
  input  wire cordic_pkg::phasor_t phasor,
  output logic                   run,
  output logic                   shot,
  output cordic_pkg::amp_t       amp,
  output cordic_pkg::angle_deg_t start,
  output cordic_pkg::angle_deg_t step
);

  import cordic_pkg::*;

  logic    req;
  logic    wr_en;
  logic    ack_q;
  wb_dat_t rd_dat;
  wb_dat_t dat_q;
  wb_dat_t result_q;
  wb_dat_t count_q;

  ////////////////////////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////////////////////////

  // ack blocks the following cycle, one transfer per two clocks
  assign req   = wb_req.cyc & wb_req.stb & ~ack_q;
  assign wr_en = req & wb_req.we;

  always_comb begin
    case (wb_req.adr)
      REG_CTRL:   rd_dat = {31'd0, run};
      REG_AMP:    rd_dat = {{20{amp[11]}}, amp};
      REG_START:  rd_dat = {{16{start[15]}}, start};
      REG_STEP:   rd_dat = {16'd0, step};
      REG_RESULT: rd_dat = result_q;
      REG_COUNT:  rd_dat = count_q;
      default:    rd_dat = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req) begin
      dat_q <= rd_dat;
    end
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q    <= 1'b0;
      run      <= 1'b0;
      shot     <= 1'b0;
      amp      <= '0;
      start    <= '0;
      step     <= '0;
      result_q <= '0;
      count_q  <= '0;
    end else begin
      ack_q <= req;
      // shot bit is a strobe, never stored
      shot  <= wr_en && wb_req.adr == REG_CTRL && wb_req.dat[CTRL_SHOT_BIT];
      if (wr_en) begin
        case (wb_req.adr)
          REG_CTRL:  run   <= wb_req.dat[CTRL_RUN_BIT];
          REG_AMP:   amp   <= amp_t'(wb_req.dat[11:0]);
          REG_START: start <= angle_deg_t'(wb_req.dat[15:0]);
          REG_STEP: begin
            if (wb_req.dat[15:0] > 16'(STEP_MAX)) begin
              step <= STEP_MAX;
            end else begin
              step <= angle_deg_t'(wb_req.dat[15:0]);
            end
          end
          default: ;
        endcase
      end
      // newest phasor only, sine in the upper half
      if (phasor.valid) begin
        result_q <= {phasor.sin, phasor.cos};
        count_q  <= count_q + 32'd1;
      end
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// File: cordic_phasor_top.sv
`timescale 1ns/1ns
`default_nettype none

module cordic_phasor_top (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire cordic_pkg::wb_req_t wb_req,
  output cordic_pkg::wb_rsp_t    wb_rsp,
  output cordic_pkg::phasor_t    phasor
);

  import cordic_pkg::*;

  logic          run;
  logic          shot;
  amp_t          amp;
  angle_deg_t    start;
  angle_deg_t    step;
  angle_sample_t sample;
  fold_t         folded;

  // control and result registers
  wb_cordic_regs u_regs (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .phasor (phasor),
    .run    (run),
    .shot   (shot),
    .amp    (amp),
    .start  (start),
    .step   (step)
  );

  phase_sweep u_sweep (
    .clk    (clk),
    .arst_n (arst_n),
    .run    (run),
    .shot   (shot),
    .amp    (amp),
    .start  (start),
    .step   (step),
    .sample (sample)
  );

  angle_fold u_fold (
    .clk    (clk),
    .arst_n (arst_n),
    .sample (sample),
    .folded (folded)
  );

  cordic_rotator u_rotator (
    .clk    (clk),
    .arst_n (arst_n),
    .folded (folded),
    .phasor (phasor)
  );

endmodule

`default_nettype wire

// File: tb_cordic_phasor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cordic_phasor;

  import cordic_pkg::*;

  localparam int  WAIT_LIMIT = 100;
  localparam int  MAX_CYCLES = 20000;
  localparam int  TOL        = 3;
  localparam real PI         = 3.14159265358979;

  logic    clk;
  logic    arst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  phasor_t phasor;

  int      seed = 22962;
  int      cyc_cnt;
  int      err_count;
  int      pass_tests;
  int      fail_tests;
  int      ack_cyc;
  wb_dat_t rd_word;
  bit      timed_out;

  // phasors seen at the port
  int      obs_cos [$];
  int      obs_sin [$];
  int      obs_cyc [$];
  int      valid_total;
  wb_dat_t last_word;

  cordic_phasor_top dut0 (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .phasor (phasor)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  always @(negedge clk) begin
    if (arst_n && phasor.valid) begin
      obs_cos.push_back(int'(phasor.cos));
      obs_sin.push_back(int'(phasor.sin));
      obs_cyc.push_back(cyc_cnt);
      last_word = {phasor.sin, phasor.cos};
      valid_total++;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus protocol properties
  ////////////////////////////////////////////////////////////

  ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
  else begin
    $display("ack stayed high for more than one cycle at %0t", $time);
    err_count++;
  end

  ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    wb_rsp.ack |-> $past(wb_req.cyc & wb_req.stb))
  else begin
    $display("ack raised without a bus request at %0t", $time);
    err_count++;
  end

  ////////////////////////////////////////////////////////////
  // checks and reference model
  ////////////////////////////////////////////////////////////

  task automatic check_equal(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
      err_count++;
    end
  endtask

  // within tolerance and never of opposite sign
  task automatic check_component(input string name, input int exp, input int act);
    int diff;
    diff = (exp > act) ? exp - act : act - exp;
    assert (diff <= TOL && !((exp > 0 && act < 0) || (exp < 0 && act > 0))) else begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
      err_count++;
    end
  endtask

  function automatic void phasor_model(input int ang, input int amp,
                                       output int exp_cos, output int exp_sin);
    int  a_abs;
    int  fold;
    int  mag;
    bit  nx;
    bit  ny;
    real rad;
    a_abs = (ang < 0) ? -ang : ang;
    nx    = a_abs > 90;
    fold  = nx ? 180 - a_abs : a_abs;
    ny    = ang < 0;
    mag   = amp;
    if (amp < 0) begin
      nx  = !nx;
      ny  = !ny;
      mag = (amp == -2048) ? 2047 : -amp;
    end
    rad     = real'(fold) * PI / 180.0;
    exp_cos = $rtoi(real'(mag) * $cos(rad));
    exp_sin = $rtoi(real'(mag) * $sin(rad));
    if (nx) exp_cos = -exp_cos;
    if (ny) exp_sin = -exp_sin;
  endfunction

  ////////////////////////////////////////////////////////////
  // waits and bus tasks
  ////////////////////////////////////////////////////////////

  // the watchdog ends the run once timed_out is set
  task automatic abort_wait(input string what);
    $display("timeout while waiting for %s", what);
    timed_out = 1'b1;
    for (int i = 0; i < 4; i++) @(posedge clk);
  endtask

  task automatic wait_ack(input string what);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
      @(negedge clk);
      if (wb_rsp.ack) begin
        seen    = 1'b1;
        ack_cyc = cyc_cnt;
        rd_word = wb_rsp.dat;
      end
    end
    if (!seen) abort_wait({"Wishbone ack on ", what});
  endtask

  task automatic wb_access(input bit we, input wb_adr_t adr, input int data);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wb_dat_t'(data)};
    wait_ack(we ? "write" : "read");
    @(posedge clk);
    wb_req <= '0;
    @(negedge clk);
    check_equal("wb_rsp.ack", 0, int'(wb_rsp.ack));
  endtask

  task automatic wb_write(input wb_adr_t adr, input int data);
    wb_access(1'b1, adr, data);
  endtask

  task automatic wb_read(input wb_adr_t adr, output int data);
    wb_access(1'b0, adr, 0);
    data = rd_word;
  endtask

  task automatic wait_results(input int n);
    for (int i = 0; i < WAIT_LIMIT && obs_cos.size() < n; i++) @(negedge clk);
    if (obs_cos.size() < n) abort_wait("phasor results");
  endtask

  task automatic obs_clear();
    obs_cos.delete();
    obs_sin.delete();
    obs_cyc.delete();
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_tests++;
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic shot_check(input int ang, input int amp);
    int ec;
    int es;
    int shot_cyc;
    obs_clear();
    wb_write(REG_AMP, amp);
    wb_write(REG_START, ang);
    wb_write(REG_CTRL, 2);
    shot_cyc = ack_cyc;
    wait_results(1);
    check_equal("phasor latency", PIPE_LATENCY, obs_cyc[0] - shot_cyc);
    phasor_model(ang, amp, ec, es);
    check_component($sformatf("phasor.cos at %0d deg", ang), ec, obs_cos[0]);
    check_component($sformatf("phasor.sin at %0d deg", ang), es, obs_sin[0]);
  endtask

  initial begin : watchdog
    while (!timed_out && cyc_cnt < MAX_CYCLES) @(posedge clk);
    if (!timed_out) $display("simulation cycle limit reached");
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    int shot_angles [11];
    int ext_amps [4];
    int ext_angles [4];
    int ov_angles [6];
    int ov_amps [6];
    int ov_ack [6];
    int errs;
    int rd;
    int ang;
    int prev;
    int ec;
    int es;
    int run_on;
    int run_off;
    int n;
    bit saw_wrap;

    clk       = 1'b0;
    arst_n    = 1'b0;
    wb_req    = '0;
    cyc_cnt   = 0;
    err_count = 0;
    timed_out = 1'b0;

    shot_angles = '{0, 30, 45, 90, 91, 135, 180, -1, -90, -135, -180};
    ext_amps    = '{2047, -2048, -1, 0};
    ext_angles  = '{0, 60, 135, -120};
    ov_angles   = '{10, -170, 95, -45, 179, -91};

    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    // reset values and register readback
    errs = err_count;
    @(negedge clk);
    check_equal("phasor.valid", 0, int'(phasor.valid));
    check_equal("wb_rsp.ack", 0, int'(wb_rsp.ack));
    wb_read(REG_COUNT, rd);
    check_equal("COUNT", 0, rd);
    wb_write(REG_AMP, -1234);
    wb_read(REG_AMP, rd);
    check_equal("AMP", -1234, rd);
    wb_write(REG_START, -77);
    wb_read(REG_START, rd);
    check_equal("START", -77, rd);
    wb_write(REG_STEP, 45);
    wb_read(REG_STEP, rd);
    check_equal("STEP", 45, rd);
    end_test("reset_regs", errs);

    errs = err_count;
    foreach (shot_angles[k]) shot_check(shot_angles[k], $random(seed) % 2048);
    end_test("single_shots", errs);

    errs = err_count;
    foreach (ext_amps[a]) begin
      foreach (ext_angles[k]) shot_check(ext_angles[k], ext_amps[a]);
    end
    end_test("amp_extremes", errs);

    // sweep across the +180 wrap
    errs = err_count;
    obs_clear();
    wb_write(REG_STEP, 7);
    wb_write(REG_AMP, 1500);
    wb_write(REG_START, 170);
    wb_write(REG_CTRL, 1);
    run_on = ack_cyc;
    repeat (40) @(posedge clk);
    wb_write(REG_CTRL, 0);
    run_off = ack_cyc;
    n = run_off - run_on;
    wait_results(n);
    repeat (4) @(negedge clk);
    check_equal("sweep result count", n, obs_cos.size());
    check_equal("sweep latency", PIPE_LATENCY, obs_cyc[0] - run_on);
    ang      = 170;
    saw_wrap = 1'b0;
    for (int k = 0; k < n && k < obs_cos.size(); k++) begin
      phasor_model(ang, 1500, ec, es);
      check_component($sformatf("phasor.cos at %0d deg", ang), ec, obs_cos[k]);
      check_component($sformatf("phasor.sin at %0d deg", ang), es, obs_sin[k]);
      check_equal("sweep sample cycle", obs_cyc[0] + k, obs_cyc[k]);
      prev = ang;
      ang  = ang + 7;
      if (ang >= 180) ang = ang - 360;
      // sine turns negative as the angle crosses the wrap
      if (prev == 177 && ang == -176 && k + 1 < obs_sin.size()) begin
        saw_wrap = obs_sin[k] > 0 && obs_sin[k+1] < 0;
      end
    end
    check_equal("sweep wrap 177 to -176", 1, int'(saw_wrap));
    end_test("sweep_wrap", errs);

    errs = err_count;
    repeat (PIPE_LATENCY + 4) @(posedge clk);
    wb_read(REG_COUNT, rd);
    check_equal("COUNT", valid_total, rd);
    wb_read(REG_RESULT, rd);
    check_equal("RESULT", int'(last_word), rd);
    end_test("count_result", errs);

    // several shots in flight at once
    errs = err_count;
    obs_clear();
    foreach (ov_angles[k]) begin
      ov_amps[k] = $random(seed) % 2048;
      wb_write(REG_AMP, ov_amps[k]);
      wb_write(REG_START, ov_angles[k]);
      wb_write(REG_CTRL, 2);
      ov_ack[k] = ack_cyc;
    end
    wait_results(6);
    foreach (ov_angles[k]) begin
      phasor_model(ov_angles[k], ov_amps[k], ec, es);
      check_component($sformatf("phasor.cos at %0d deg", ov_angles[k]), ec, obs_cos[k]);
      check_component($sformatf("phasor.sin at %0d deg", ov_angles[k]), es, obs_sin[k]);
      check_equal("overlap latency", PIPE_LATENCY, obs_cyc[k] - ov_ack[k]);
    end
    end_test("overlap_shots", errs);

    $display("tests passed %0d failed %0d errors %0d", pass_tests, fail_tests, err_count);
    if (err_count == 0 && fail_tests == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
cordic_pkg.sv
angle_fold.sv
cordic_rotator.sv
phase_sweep.sv
wb_cordic_regs.sv
cordic_phasor_top.sv
tb_cordic_phasor.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_cordic_phasor \
  -f compile.f \
  -Mdir obj_dir \
  -o sim_cordic_phasor

./obj_dir/sim_cordic_phasor | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
